//--- src/elem_defs.svh
////////////////////////////////////////////////////////////////////////////
// sizes for one vector register at fixed LMUL of 1, with no grouping
// all modules are built for these values and take no parameters
////////////////////////////////////////////////////////////////////////////

`ifndef ELEM_DEFS_SVH
`define ELEM_DEFS_SVH

// vector register width in bits
`define ELEM_VREG_W 128

// scalar result width
`define ELEM_XLEN 32

// register file address width
`define ELEM_VADDR_W 5

// vl width, holds 0 up to one bit per mask element
`define ELEM_VL_W 8

// element limit for mask operations
`define ELEM_MAX_ELEMS 128

`endif

//--- src/elem_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// vector configuration types, only SEW is configurable
////////////////////////////////////////////////////////////////////////////

package elem_cfg_pkg;

    // element width, the last code is unused
    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

endpackage

//--- src/elem_op_pkg.sv
////////////////////////////////////////////////////////////////////////////
// operation set of the element unit and its sequencer states
// codes 10 to 15 are unused and behave as no operation
////////////////////////////////////////////////////////////////////////////

package elem_op_pkg;

    typedef enum logic [3:0] {
        OP_REDSUM  = 4'd0,
        OP_REDAND  = 4'd1,
        OP_REDOR   = 4'd2,
        OP_REDXOR  = 4'd3,
        OP_REDMINU = 4'd4,
        OP_REDMIN  = 4'd5,
        OP_REDMAXU = 4'd6,
        OP_REDMAX  = 4'd7,
        OP_VPOPC   = 4'd8,
        OP_VFIRST  = 4'd9
    } elem_op_e;

    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        RD_INIT      = 3'd1,
        RD_DATA      = 3'd2,
        RUN          = 3'd3,
        DONE         = 3'd4,
        WAIT_REQ_LOW = 3'd5
    } seq_state_e;

    // mask operations read one register and walk bits
    function automatic logic is_mask_op(elem_op_e op);
        return (op == OP_VPOPC) || (op == OP_VFIRST);
    endfunction

endpackage

//--- src/elem_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// one operation at a time, the next request is acked only after the
// result pulse and after the previous ack has dropped
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elem_defs.svh"

module elem_sequencer (
    input  logic                     clk_i,
    input  logic                     async_rst_ni,
    input  logic                     op_req_i,
    output logic                     op_ack_o,
    input  elem_op_pkg::elem_op_e    op_i,
    input  elem_cfg_pkg::vsew_e      vsew_i,
    input  logic [`ELEM_VL_W-1:0]    vl_i,
    input  logic [`ELEM_VADDR_W-1:0] vs1_i,
    input  logic [`ELEM_VADDR_W-1:0] vs2_i,
    output logic [`ELEM_VADDR_W-1:0] vreg_rd_addr_o,
    output logic                     load_init_o,
    output logic                     load_data_o,
    output logic                     step_o,
    output logic                     first_o,
    output logic                     last_o,
    output elem_op_pkg::elem_op_e    op_o,
    output elem_cfg_pkg::vsew_e      vsew_o
);
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;

    typedef logic [`ELEM_VL_W-1:0] vl_t;

    seq_state_e state_q, state_d;
    logic ack_q;
    logic accept;
    vl_t cnt_q;
    vl_t vl_lim, vl_eff;

    // operation captured at acceptance
    elem_op_e op_q;
    vsew_e vsew_q;
    logic [`ELEM_VADDR_W-1:0] vs1_q, vs2_q;
    vl_t last_idx_q;
    logic vl_nz_q;

    assign accept = (state_q == IDLE) && op_req_i && !ack_q;

    // element count of one register at the requested width
    always_comb begin
        vl_lim = vl_t'(`ELEM_MAX_ELEMS);
        if (!is_mask_op(op_i)) begin
            case (vsew_i)
                VSEW_8:  vl_lim = vl_t'(`ELEM_VREG_W / 8);
                VSEW_16: vl_lim = vl_t'(`ELEM_VREG_W / 16);
                default: vl_lim = vl_t'(`ELEM_VREG_W / 32);
            endcase
        end
        vl_eff = (vl_i > vl_lim) ? vl_lim : vl_i;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:         if (accept) state_d = RD_INIT;
            // mask operations have no data register to read
            RD_INIT:      state_d = is_mask_op(op_q) ? RUN : RD_DATA;
            RD_DATA:      state_d = RUN;
            RUN:          if (cnt_q == last_idx_q) state_d = DONE;
            DONE:         state_d = WAIT_REQ_LOW;
            WAIT_REQ_LOW: if (!ack_q) state_d = IDLE;
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!op_req_i) begin
                ack_q <= 1'b0;
            end
            cnt_q <= (state_q == RUN) ? cnt_q + vl_t'(1) : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q       <= op_i;
            vsew_q     <= vsew_i;
            vs1_q      <= vs1_i;
            vs2_q      <= vs2_i;
            vl_nz_q    <= (vl_eff != '0);
            last_idx_q <= (vl_eff != '0) ? vl_eff - vl_t'(1) : '0;
        end
    end

    // vs2 goes out while accepting, vs1 follows for reductions
    always_comb begin
        case (state_q)
            IDLE:    vreg_rd_addr_o = vs2_i;
            RD_INIT: vreg_rd_addr_o = is_mask_op(op_q) ? vs2_q : vs1_q;
            default: vreg_rd_addr_o = vs2_q;
        endcase
    end

    // read data arrives one cycle after each address
    assign load_init_o = (state_q == RD_INIT);
    assign load_data_o = (state_q == RD_DATA);

    // with vl of 0 the single RUN cycle marks first and last but never steps
    assign step_o  = (state_q == RUN) && vl_nz_q;
    assign first_o = (state_q == RUN) && (cnt_q == '0);
    assign last_o  = (state_q == RUN) && (cnt_q == last_idx_q);

    assign op_ack_o = ack_q;
    assign op_o     = op_q;
    assign vsew_o   = vsew_q;

endmodule

//--- src/elem_operand_shift.sv
////////////////////////////////////////////////////////////////////////////
// one shift register serves the data register, or the mask register
// for mask operations, elements leave zero-extended at bit 0
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elem_defs.svh"

module elem_operand_shift (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  logic [`ELEM_VREG_W-1:0] vreg_rd_i,
    input  logic                   load_init_i,
    input  logic                   load_data_i,
    input  logic                   step_i,
    input  elem_op_pkg::elem_op_e  op_i,
    input  elem_cfg_pkg::vsew_e    vsew_i,
    output logic [`ELEM_XLEN-1:0]  init_elem_o,
    output logic [`ELEM_XLEN-1:0]  elem_o,
    output logic                   mask_bit_o
);
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;

    logic [`ELEM_VREG_W-1:0] shift_q, shift_d;
    logic [`ELEM_XLEN-1:0]   init_q;

    // element 0 of a register at the given width
    function automatic logic [`ELEM_XLEN-1:0] low_elem(logic [`ELEM_VREG_W-1:0] v,
                                                      vsew_e sew);
        case (sew)
            VSEW_8:  return {{(`ELEM_XLEN-8){1'b0}}, v[7:0]};
            VSEW_16: return {{(`ELEM_XLEN-16){1'b0}}, v[15:0]};
            default: return v[`ELEM_XLEN-1:0];
        endcase
    endfunction

    always_comb begin
        shift_d = shift_q;
        if (load_data_i || (load_init_i && is_mask_op(op_i))) begin
            shift_d = vreg_rd_i;
        end else if (step_i) begin
            if (is_mask_op(op_i)) begin
                shift_d = shift_q >> 1;
            end else begin
                case (vsew_i)
                    VSEW_8:  shift_d = shift_q >> 8;
                    VSEW_16: shift_d = shift_q >> 16;
                    default: shift_d = shift_q >> 32;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            shift_q <= '0;
            init_q  <= '0;
        end else begin
            shift_q <= shift_d;
            if (load_init_i) begin
                init_q <= low_elem(vreg_rd_i, vsew_i);
            end
        end
    end

    assign init_elem_o = init_q;
    assign elem_o      = low_elem(shift_q, vsew_i);
    assign mask_bit_o  = shift_q[0];

endmodule

//--- src/elem_mask_scan.sv
////////////////////////////////////////////////////////////////////////////
// scan_o already includes the bit of the current step
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elem_defs.svh"

module elem_mask_scan (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  logic                  step_i,
    input  logic                  first_i,
    input  logic                  mask_bit_i,
    input  elem_op_pkg::elem_op_e op_i,
    output logic [`ELEM_XLEN-1:0] scan_o
);
    import elem_op_pkg::*;

    logic [`ELEM_VL_W-1:0] idx_q, base_idx;
    logic [`ELEM_XLEN-1:0] res_q, res_d, base_res;

    always_comb begin
        // first restarts index and result
        base_idx = first_i ? '0 : idx_q;
        base_res = res_q;
        if (first_i) begin
            base_res = (op_i == OP_VFIRST) ? '1 : '0;
        end
        res_d = base_res;
        if (step_i) begin
            if (op_i == OP_VPOPC) begin
                res_d = base_res + {{(`ELEM_XLEN-1){1'b0}}, mask_bit_i};
            end else if (op_i == OP_VFIRST && mask_bit_i && base_res[`ELEM_XLEN-1]) begin
                // still all ones, so this is the first set bit
                res_d = {{(`ELEM_XLEN-`ELEM_VL_W){1'b0}}, base_idx};
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            idx_q <= '0;
            res_q <= '0;
        end else if (first_i || step_i) begin
            idx_q <= base_idx + {{(`ELEM_VL_W-1){1'b0}}, step_i};
            res_q <= res_d;
        end
    end

    assign scan_o = res_d;

endmodule

//--- src/elem_result_alu.sv
////////////////////////////////////////////////////////////////////////////
// operands come zero-extended, upper accumulator bits are don't care
// and the result is sign-extended from the element width
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elem_defs.svh"

module elem_result_alu (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  logic                  step_i,
    input  logic                  first_i,
    input  logic                  last_i,
    input  elem_op_pkg::elem_op_e op_i,
    input  elem_cfg_pkg::vsew_e   vsew_i,
    input  logic [`ELEM_XLEN-1:0] init_elem_i,
    input  logic [`ELEM_XLEN-1:0] elem_i,
    input  logic [`ELEM_XLEN-1:0] scan_i,
    output logic                  xreg_valid_o,
    output logic [`ELEM_XLEN-1:0] xreg_o
);
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;

    logic [`ELEM_XLEN-1:0] acc_q, acc_d, base, comb_res, xreg_q;
    logic [`ELEM_XLEN:0]   a_ext, b_ext, fin_ext;
    logic                  signed_cmp;
    logic                  a_lt, a_gt;
    logic                  xreg_valid_q;

    // extend from the element width by one extra bit, signed or not,
    // so a single signed compare covers min, max, minu and maxu
    function automatic logic [`ELEM_XLEN:0] ext(logic [`ELEM_XLEN-1:0] x, vsew_e sew,
                                               logic sgn);
        case (sew)
            VSEW_8:  return {{(`ELEM_XLEN-7){sgn & x[7]}}, x[7:0]};
            VSEW_16: return {{(`ELEM_XLEN-15){sgn & x[15]}}, x[15:0]};
            default: return {sgn & x[`ELEM_XLEN-1], x};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reduction step

    always_comb begin
        base       = first_i ? init_elem_i : acc_q;
        signed_cmp = (op_i == OP_REDMIN) || (op_i == OP_REDMAX);
        a_ext      = ext(elem_i, vsew_i, signed_cmp);
        b_ext      = ext(base, vsew_i, signed_cmp);
        a_lt       = $signed(a_ext) < $signed(b_ext);
        a_gt       = $signed(a_ext) > $signed(b_ext);
        case (op_i)
            OP_REDSUM:            comb_res = base + elem_i;
            OP_REDAND:            comb_res = base & elem_i;
            OP_REDOR:             comb_res = base | elem_i;
            OP_REDXOR:            comb_res = base ^ elem_i;
            OP_REDMINU, OP_REDMIN: comb_res = a_lt ? elem_i : base;
            OP_REDMAXU, OP_REDMAX: comb_res = a_gt ? elem_i : base;
            default:              comb_res = base;
        endcase
        // a cycle without step keeps the seed, this covers vl of 0
        acc_d   = step_i ? comb_res : base;
        fin_ext = ext(acc_d, vsew_i, 1'b1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulator and scalar write-back

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            acc_q        <= '0;
            xreg_q       <= '0;
            xreg_valid_q <= 1'b0;
        end else begin
            if (first_i || step_i) begin
                acc_q <= acc_d;
            end
            if (last_i) begin
                xreg_q <= is_mask_op(op_i) ? scan_i : fin_ext[`ELEM_XLEN-1:0];
            end
            xreg_valid_q <= last_i;
        end
    end

    assign xreg_valid_o = xreg_valid_q;
    assign xreg_o       = xreg_q;

endmodule

//--- src/elem_unit.sv
////////////////////////////////////////////////////////////////////////////
// reductions and mask scans over one vector register, scalar result only
// the result pulse has no back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elem_defs.svh"

module elem_unit (
    input  logic                     clk_i,
    input  logic                     async_rst_ni,
    // operation issue
    input  logic                     op_req_i,
    output logic                     op_ack_o,
    input  elem_op_pkg::elem_op_e    op_i,
    input  elem_cfg_pkg::vsew_e      vsew_i,
    input  logic [`ELEM_VL_W-1:0]    vl_i,
    input  logic [`ELEM_VADDR_W-1:0] vs1_i,
    input  logic [`ELEM_VADDR_W-1:0] vs2_i,
    // register file read, data one cycle after the address
    output logic [`ELEM_VADDR_W-1:0] vreg_rd_addr_o,
    input  logic [`ELEM_VREG_W-1:0]  vreg_rd_i,
    // scalar write-back
    output logic                     xreg_valid_o,
    output logic [`ELEM_XLEN-1:0]    xreg_o
);

    logic                  load_init, load_data, step, first, last;
    elem_op_pkg::elem_op_e seq_op;
    elem_cfg_pkg::vsew_e   seq_vsew;
    logic [`ELEM_XLEN-1:0] init_elem, elem, scan;
    logic                  mask_bit;

    elem_sequencer u_seq (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_req_i       (op_req_i),
        .op_ack_o       (op_ack_o),
        .op_i           (op_i),
        .vsew_i         (vsew_i),
        .vl_i           (vl_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .load_init_o    (load_init),
        .load_data_o    (load_data),
        .step_o         (step),
        .first_o        (first),
        .last_o         (last),
        .op_o           (seq_op),
        .vsew_o         (seq_vsew)
    );

    elem_operand_shift u_shift (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .vreg_rd_i    (vreg_rd_i),
        .load_init_i  (load_init),
        .load_data_i  (load_data),
        .step_i       (step),
        .op_i         (seq_op),
        .vsew_i       (seq_vsew),
        .init_elem_o  (init_elem),
        .elem_o       (elem),
        .mask_bit_o   (mask_bit)
    );

    elem_mask_scan u_scan (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .step_i       (step),
        .first_i      (first),
        .mask_bit_i   (mask_bit),
        .op_i         (seq_op),
        .scan_o       (scan)
    );

    elem_result_alu u_alu (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .step_i       (step),
        .first_i      (first),
        .last_i       (last),
        .op_i         (seq_op),
        .vsew_i       (seq_vsew),
        .init_elem_i  (init_elem),
        .elem_i       (elem),
        .scan_i       (scan),
        .xreg_valid_o (xreg_valid_o),
        .xreg_o       (xreg_o)
    );

endmodule

//--- verification/elem_unit_tb.sv
////////////////////////////////////////////////////////////////////////////
// drives elem_unit through reductions and mask scans against a 32-entry
// register file model, results come from a reference model of the rules
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elem_defs.svh"

module elem_unit_tb;
    import elem_cfg_pkg::*;
    import elem_op_pkg::*;

    localparam int ACK_TIMEOUT    = 20;
    localparam int RESULT_TIMEOUT = 300;

    logic                     clk_i;
    logic                     async_rst_ni;
    logic                     op_req_i;
    logic                     op_ack_o;
    elem_op_e                 op_i;
    vsew_e                    vsew_i;
    logic [`ELEM_VL_W-1:0]    vl_i;
    logic [`ELEM_VADDR_W-1:0] vs1_i;
    logic [`ELEM_VADDR_W-1:0] vs2_i;
    logic [`ELEM_VADDR_W-1:0] vreg_rd_addr_o;
    logic [`ELEM_VREG_W-1:0]  vreg_rd_i;
    logic                     xreg_valid_o;
    logic [`ELEM_XLEN-1:0]    xreg_o;

    // register file model and bookkeeping
    logic [`ELEM_VREG_W-1:0]  regfile [32];
    logic [31:0]              rng_state;
    logic [`ELEM_XLEN-1:0]    exp_result;
    logic [`ELEM_VADDR_W-1:0] cur_vs1;
    logic [`ELEM_VADDR_W-1:0] cur_vs2;
    logic                     cur_mask;
    logic                     req_seen;
    logic                     busy;
    logic                     hung;
    logic                     ack_prev;
    int                       ack_rises;
    int                       pulses;
    int                       err_cnt;
    int                       test_err_base;
    int                       tests_run;
    int                       tests_failed;

    elem_op_e logic_ops [4] = '{OP_REDSUM, OP_REDAND, OP_REDOR, OP_REDXOR};
    elem_op_e cmp_ops [4]   = '{OP_REDMINU, OP_REDMIN, OP_REDMAXU, OP_REDMAX};
    vsew_e    sew_list [3]  = '{VSEW_8, VSEW_16, VSEW_32};
    int       full_vl [3]   = '{16, 8, 4};

    elem_unit u_dut (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_req_i       (op_req_i),
        .op_ack_o       (op_ack_o),
        .op_i           (op_i),
        .vsew_i         (vsew_i),
        .vl_i           (vl_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .xreg_valid_o   (xreg_valid_o),
        .xreg_o         (xreg_o)
    );

    always #2 clk_i = ~clk_i;

    // registered read, data one cycle after the address
    always @(posedge clk_i) begin
        vreg_rd_i <= regfile[vreg_rd_addr_o];
    end

    // accepted operations and result pulses seen so far
    always @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ack_prev  <= 1'b0;
            ack_rises <= 0;
            pulses    <= 0;
        end else begin
            ack_prev <= op_ack_o;
            if (op_ack_o && !ack_prev) begin
                ack_rises <= ack_rises + 1;
            end
            if (xreg_valid_o) begin
                pulses <= pulses + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    ack_idle: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !req_seen |-> !op_ack_o)
        else begin
            err_cnt++;
            $display("mismatch at %0t: op_ack_o got %b expected 0", $time, op_ack_o);
        end

    valid_idle: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !req_seen |-> !xreg_valid_o)
        else begin
            err_cnt++;
            $display("mismatch at %0t: xreg_valid_o got %b expected 0", $time, xreg_valid_o);
        end

    ack_rise: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        $rose(op_ack_o) |-> $past(op_req_i))
        else begin
            err_cnt++;
            $display("op_ack_o rose at %0t without a pending request", $time);
        end

    ack_fall: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        $fell(op_ack_o) |-> !$past(op_req_i))
        else begin
            err_cnt++;
            $display("op_ack_o fell at %0t while op_req_i was still high", $time);
        end

    // every earlier operation delivered its pulse before the next ack
    pulse_per_op: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        $rose(op_ack_o) |-> (pulses == ack_rises))
        else begin
            err_cnt++;
            $display("mismatch at %0t: result pulses got %0d expected %0d",
                     $time, pulses, ack_rises);
        end

    pulse_owner: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        xreg_valid_o |-> (pulses < ack_rises))
        else begin
            err_cnt++;
            $display("xreg_valid_o pulsed at %0t with no operation outstanding", $time);
        end

    pulse_width: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        xreg_valid_o |=> !xreg_valid_o)
        else begin
            err_cnt++;
            $display("xreg_valid_o stayed high for more than one cycle at %0t", $time);
        end

    result_value: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        xreg_valid_o |-> (xreg_o == exp_result))
        else begin
            err_cnt++;
            $display("mismatch at %0t: xreg_o got %h expected %h", $time, xreg_o, exp_result);
        end

    // mask operations must never address vs1
    read_addr: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        busy |-> (vreg_rd_addr_o == cur_vs2 || (!cur_mask && vreg_rd_addr_o == cur_vs1)))
        else begin
            err_cnt++;
            $display("mismatch at %0t: vreg_rd_addr_o got %0d expected %0d (vs2) or %0d (vs1)",
                     $time, vreg_rd_addr_o, cur_vs2, cur_vs1);
        end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [`ELEM_XLEN-1:0] expected_result(
            input elem_op_e op, input vsew_e sew, input int vl,
            input logic [`ELEM_VREG_W-1:0] init_reg,
            input logic [`ELEM_VREG_W-1:0] data_reg);
        int                      w;
        int                      lim;
        int                      cnt;
        logic [31:0]             wmask;
        logic [31:0]             acc;
        logic [31:0]             e;
        logic [`ELEM_VREG_W-1:0] sh;
        logic signed [31:0]      sa;
        logic signed [31:0]      se;
        if (op == OP_VPOPC || op == OP_VFIRST) begin
            lim = (vl > `ELEM_MAX_ELEMS) ? `ELEM_MAX_ELEMS : vl;
            cnt = 0;
            for (int i = 0; i < lim; i++) begin
                if (init_reg[i]) begin
                    if (op == OP_VFIRST) begin
                        return 32'(i);
                    end
                    cnt++;
                end
            end
            return (op == OP_VFIRST) ? 32'hffff_ffff : 32'(cnt);
        end
        w     = (sew == VSEW_8) ? 8 : (sew == VSEW_16) ? 16 : 32;
        lim   = (vl < `ELEM_VREG_W / w) ? vl : `ELEM_VREG_W / w;
        wmask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        acc   = init_reg[31:0] & wmask;
        for (int i = 0; i < lim; i++) begin
            sh = data_reg >> (i * w);
            e  = sh[31:0] & wmask;
            // element sign bit moved up to bit 31 for signed compares
            sa = acc << (32 - w);
            se = e << (32 - w);
            case (op)
                OP_REDSUM:  acc = (acc + e) & wmask;
                OP_REDAND:  acc = acc & e;
                OP_REDOR:   acc = acc | e;
                OP_REDXOR:  acc = acc ^ e;
                OP_REDMINU: if (e < acc) acc = e;
                OP_REDMAXU: if (e > acc) acc = e;
                OP_REDMIN:  if (se < sa) acc = e;
                OP_REDMAX:  if (se > sa) acc = e;
                default:    acc = acc;
            endcase
        end
        sa = acc << (32 - w);
        return sa >>> (32 - w);
    endfunction

    task automatic report_hang(input string what);
        hung = 1'b1;
        err_cnt++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic pick_regs(output int a, output int b);
        a = 2 + int'(next_rand() % 28);
        b = 2 + int'(next_rand() % 28);
        if (b == a) begin
            b = (a == 29) ? 2 : a + 1;
        end
    endtask

    // waits until every accepted operation has delivered its result pulse
    task automatic wait_results();
        int t;
        if (hung) begin
            return;
        end
        t = 0;
        do begin
            @(negedge clk_i);
            t++;
        end while (pulses < ack_rises && t < RESULT_TIMEOUT);
        if (pulses < ack_rises) begin
            report_hang("no xreg_valid_o pulse for the accepted operation");
            return;
        end
        busy = 1'b0;
    endtask

    // four-phase issue that returns once the ack has dropped, so the next
    // request goes up while this operation is still running
    task automatic issue_op(input elem_op_e op, input vsew_e sew, input int vl,
                            input int r1, input int r2);
        int t;
        if (hung) begin
            return;
        end
        @(posedge clk_i);
        op_i     <= op;
        vsew_i   <= sew;
        vl_i     <= vl[`ELEM_VL_W-1:0];
        vs1_i    <= r1[`ELEM_VADDR_W-1:0];
        vs2_i    <= r2[`ELEM_VADDR_W-1:0];
        op_req_i <= 1'b1;
        req_seen <= 1'b1;
        // the previous result has to come out before this request is acked
        wait_results();
        if (hung) begin
            return;
        end
        @(posedge clk_i);
        exp_result <= expected_result(op, sew, vl, regfile[r2], regfile[r1]);
        cur_vs1    <= r1[`ELEM_VADDR_W-1:0];
        cur_vs2    <= r2[`ELEM_VADDR_W-1:0];
        cur_mask   <= (op == OP_VPOPC) || (op == OP_VFIRST);
        t = 0;
        do begin
            @(negedge clk_i);
            t++;
        end while (!op_ack_o && t < ACK_TIMEOUT);
        if (!op_ack_o) begin
            report_hang("op_ack_o did not rise after op_req_i");
            return;
        end
        busy = 1'b1;
        @(posedge clk_i);
        op_req_i <= 1'b0;
        t = 0;
        do begin
            @(negedge clk_i);
            t++;
        end while (op_ack_o && t < ACK_TIMEOUT);
        if (op_ack_o) begin
            report_hang("op_ack_o did not fall after op_req_i dropped");
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        wait_results();
        // let the checks on the last result settle
        repeat (2) @(negedge clk_i);
        errs = err_cnt - test_err_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-14s %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
        test_err_base = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        int r1;
        int r2;
        int vl;
        clk_i         = 1'b0;
        async_rst_ni  = 1'b0;
        op_req_i      = 1'b0;
        op_i          = OP_REDSUM;
        vsew_i        = VSEW_8;
        vl_i          = '0;
        vs1_i         = '0;
        vs2_i         = '0;
        vreg_rd_i     = '0;
        exp_result    = '0;
        cur_vs1       = '0;
        cur_vs2       = '0;
        cur_mask      = 1'b0;
        req_seen      = 1'b0;
        busy          = 1'b0;
        hung          = 1'b0;
        err_cnt       = 0;
        test_err_base = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rng_state     = 32'h9365841b;
        for (int a = 0; a < 32; a++) begin
            for (int w = 0; w < `ELEM_VREG_W / 32; w++) begin
                regfile[a][w*32 +: 32] = next_rand();
            end
        end
        // signed extremes for min and max
        regfile[30] = {4{32'h80ff_7f01}};
        // no set mask bit in the low 40 elements
        regfile[1][39:0] = '0;

        repeat (8) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        repeat (6) @(posedge clk_i);
        finish_test("reset_idle");

        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < 4; k++) begin
                pick_regs(r1, r2);
                issue_op(logic_ops[k], sew_list[s], full_vl[s], r1, r2);
            end
        end
        // vl beyond the element count
        pick_regs(r1, r2);
        issue_op(OP_REDSUM, VSEW_8, 200, r1, r2);
        finish_test("logic_reduce");

        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 4; k++) begin
                pick_regs(r1, r2);
                issue_op(cmp_ops[k], sew_list[s], full_vl[s], 30, r2);
                issue_op(cmp_ops[k], sew_list[s], full_vl[s], r1, r2);
            end
        end
        finish_test("min_max");

        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 4; k++) begin
                pick_regs(r1, r2);
                vl = 1 + int'(next_rand() % 32'(full_vl[s] - 1));
                issue_op(cmp_ops[k], sew_list[s], vl, 30, r2);
                issue_op(cmp_ops[k], sew_list[s], 0, r1, r2);
            end
        end
        finish_test("partial_vl");

        for (int n = 0; n < 12; n++) begin
            pick_regs(r1, r2);
            vl = int'(next_rand() % 256);
            issue_op((n % 2 == 0) ? OP_VPOPC : OP_VFIRST, VSEW_8, vl, r1, r2);
        end
        issue_op(OP_VFIRST, VSEW_8, 40, 5, 1);
        issue_op(OP_VPOPC, VSEW_8, 40, 5, 1);
        issue_op(OP_VFIRST, VSEW_8, 0, 5, 7);
        finish_test("mask_ops");

        assert (pulses == ack_rises) else begin
            err_cnt++;
            $display("mismatch at %0t: result pulses got %0d expected %0d",
                     $time, pulses, ack_rises);
        end
        finish_test("handshake");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
src/elem_cfg_pkg.sv
src/elem_op_pkg.sv
src/elem_sequencer.sv
src/elem_operand_shift.sv
src/elem_mask_scan.sv
src/elem_result_alu.sv
src/elem_unit.sv
verification/elem_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the element unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -Wno-fatal \
    -f vlog.f --top-module elem_unit_tb

./obj_dir/Velem_unit_tb > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
